// ==== include/ex_model.svh ====
// reference behavior for the execute stage checks
// include inside a module, needs ex_pkg compiled first
// results are the architectural values, not timing
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

function automatic ex_pkg::word_t model_alu(ex_pkg::alu_func_t func,
                                            ex_pkg::word_t a, ex_pkg::word_t b);
  case (func)
    ex_pkg::alu_addq:   return a + b;
    ex_pkg::alu_subq:   return a - b;
    ex_pkg::alu_and:    return a & b;
    ex_pkg::alu_bic:    return a & ~b;
    ex_pkg::alu_bis:    return a | b;
    ex_pkg::alu_ornot:  return a | ~b;
    ex_pkg::alu_xor:    return a ^ b;
    ex_pkg::alu_eqv:    return ~(a ^ b);
    ex_pkg::alu_srl:    return a >> b[5:0];
    ex_pkg::alu_sll:    return a << b[5:0];
    ex_pkg::alu_sra:    return $signed(a) >>> b[5:0];
    ex_pkg::alu_cmpult: return {63'd0, a < b};
    ex_pkg::alu_cmpeq:  return {63'd0, a == b};
    ex_pkg::alu_cmpule: return {63'd0, a <= b};
    ex_pkg::alu_cmplt:  return {63'd0, $signed(a) < $signed(b)};
    ex_pkg::alu_cmple:  return {63'd0, $signed(a) <= $signed(b)};
    default:            return 64'hdeadbeefbaadbeef;
  endcase
endfunction

// operand a as the stage should select it
function automatic ex_pkg::word_t model_opa(ex_pkg::opa_sel_t sel, ex_pkg::word_t t1,
                                            ex_pkg::inst_t inst, ex_pkg::word_t npc);
  case (sel)
    ex_pkg::opa_is_rega:     return t1;
    ex_pkg::opa_is_mem_disp: return 64'($signed(inst[15:0]));
    ex_pkg::opa_is_npc:      return npc;
    default:                 return ~64'h3;
  endcase
endfunction

// operand b, br disp is a word offset
function automatic ex_pkg::word_t model_opb(ex_pkg::opb_sel_t sel, ex_pkg::word_t t2,
                                            ex_pkg::inst_t inst);
  case (sel)
    ex_pkg::opb_is_regb:    return t2;
    ex_pkg::opb_is_alu_imm: return 64'(inst[20:13]);
    default:                return 64'($signed(inst[20:0])) << 2;
  endcase
endfunction

// lbc, eq, lt, le, bit 2 inverts
function automatic logic model_brcond(logic [2:0] bits, ex_pkg::word_t a);
  logic c;
  case (bits[1:0])
    2'b00:   c = (a[0] == 1'b0);
    2'b01:   c = (a == 64'd0);
    2'b10:   c = ($signed(a) < 0);
    default: c = ($signed(a) <= 0);
  endcase
  return bits[2] ? !c : c;
endfunction

function automatic ex_pkg::word_t model_mult(ex_pkg::word_t a, ex_pkg::word_t b);
  return a * b;
endfunction

`endif

// ==== bench/ex_stage_tb.sv ====
// testbench for the execute stage, mult_stages fixed at 4
// alu lanes expected 2 cycles after issue, lane 3 mult_stages+2
// tags carry the lane number in the top bits, so lanes never collide
// outputs are checked on the falling edge
`timescale 1ns/100ps

module ex_stage_tb;

  localparam int mult_stages  = 4;
  localparam int half_period  = 4;
  localparam int reset_cycles = 10;
  localparam int main_cycles  = 192;
  localparam int idle_cycles  = 20;
  // twice the planned run plus pipeline drain
  localparam int limit_cycles = 2 * (reset_cycles + main_cycles + idle_cycles + mult_stages + 8);

  // shift and signed compare corner values
  localparam ex_pkg::word_t edge_vals [8] = '{64'd0, 64'd1, 64'hffff_ffff_ffff_ffff,
    64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, 64'd63, 64'd64, 64'd2};

  `include "ex_model.svh"

  logic                                      clock;
  logic                                      rst_n;
  logic              [ex_pkg::num_lanes-1:0] issue_valid;
  ex_pkg::tag_t      [ex_pkg::num_lanes-1:0] issue_tag;
  ex_pkg::inst_t     [ex_pkg::num_lanes-1:0] issue_inst;
  ex_pkg::word_t     [ex_pkg::num_lanes-1:0] issue_npc;
  ex_pkg::alu_func_t [ex_pkg::num_lanes-1:0] issue_alu_func;
  ex_pkg::opa_sel_t  [ex_pkg::num_lanes-1:0] issue_opa_sel;
  ex_pkg::opb_sel_t  [ex_pkg::num_lanes-1:0] issue_opb_sel;
  ex_pkg::word_t     [ex_pkg::num_lanes-1:0] t1_value;
  ex_pkg::word_t     [ex_pkg::num_lanes-1:0] t2_value;
  logic                                      issue_cond_branch;
  logic                                      issue_uncond_branch;
  logic              [ex_pkg::num_lanes-1:0] cdb_valid;
  ex_pkg::tag_t      [ex_pkg::num_lanes-1:0] cdb_tag;
  ex_pkg::word_t     [ex_pkg::num_lanes-1:0] cdb_value;
  logic                                      take_branch;
  ex_pkg::word_t                             redirect_pc;

  int            cycle;
  // scoreboard, one set of queues per lane
  string         exp_name  [ex_pkg::num_lanes][$];
  ex_pkg::tag_t  exp_tag   [ex_pkg::num_lanes][$];
  ex_pkg::word_t exp_value [ex_pkg::num_lanes][$];
  int            exp_due   [ex_pkg::num_lanes][$];
  logic          exp_take  [$];
  ex_pkg::word_t exp_pc    [$];

  ex_stage #(.mult_stages(mult_stages)) ex_stage_inst (.*);

  always #half_period clock = ~clock;

  always @(posedge clock) cycle <= cycle + 1;

  ////////////////////
  // helpers
  ////////////////////
  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, ex_pkg::word_t expected, ex_pkg::word_t actual);
    assert (expected == actual)
      else stop_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
  endtask

  // half corner values, half full random
  function automatic ex_pkg::word_t pick_operand();
    if ($urandom_range(1) == 0) begin
      return edge_vals[$urandom_range(7)];
    end
    return {$urandom, $urandom};
  endfunction

  function automatic logic queues_pending();
    logic busy;
    busy = 1'b0;
    for (int l = 0; l < ex_pkg::num_lanes; l++) begin
      if (exp_tag[l].size() != 0) begin
        busy = 1'b1;
      end
    end
    return busy;
  endfunction

  // junk on every control, nothing valid
  task automatic drive_idle();
    issue_valid = '0;
    for (int l = 0; l < ex_pkg::num_lanes; l++) begin
      issue_tag[l]      = ex_pkg::tag_t'($urandom);
      issue_inst[l]     = $urandom;
      issue_npc[l]      = {$urandom, $urandom};
      issue_alu_func[l] = ex_pkg::alu_func_t'(5'($urandom));
      issue_opa_sel[l]  = ex_pkg::opa_sel_t'(2'($urandom));
      issue_opb_sel[l]  = ex_pkg::opb_sel_t'(2'($urandom));
      t1_value[l]       = {$urandom, $urandom};
      t2_value[l]       = {$urandom, $urandom};
    end
    issue_cond_branch   = 1'($urandom);
    issue_uncond_branch = 1'($urandom);
  endtask

  task automatic issue_lane(int l, string name, ex_pkg::alu_func_t func,
                            ex_pkg::opa_sel_t opa_sel, ex_pkg::opb_sel_t opb_sel,
                            ex_pkg::inst_t inst, ex_pkg::word_t t1, ex_pkg::word_t t2);
    ex_pkg::word_t npc;
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    ex_pkg::tag_t  tag;
    npc = {$urandom, $urandom} & ~64'h3;
    tag = {3'(l), 3'($urandom)};
    a   = model_opa(opa_sel, t1, inst, npc);
    b   = model_opb(opb_sel, t2, inst);
    issue_valid[l]    = 1'b1;
    issue_tag[l]      = tag;
    issue_inst[l]     = inst;
    issue_npc[l]      = npc;
    issue_alu_func[l] = func;
    issue_opa_sel[l]  = opa_sel;
    issue_opb_sel[l]  = opb_sel;
    t1_value[l]       = t1;
    t2_value[l]       = t2;
    exp_name[l].push_back(name);
    exp_tag[l].push_back(tag);
    if (l == ex_pkg::lane_mult) begin
      exp_value[l].push_back(model_mult(a, b));
      exp_due[l].push_back(cycle + mult_stages + 2);
    end else begin
      exp_value[l].push_back(model_alu(func, a, b));
      exp_due[l].push_back(cycle + 2);
    end
  endtask

  // kind 0 plain, 1 conditional, 2 unconditional
  task automatic issue_branch(logic [2:0] cond_bits, int kind);
    ex_pkg::inst_t inst;
    ex_pkg::word_t t1;
    logic          take;
    inst        = $urandom;
    inst[28:26] = cond_bits;
    t1          = pick_operand();
    issue_lane(ex_pkg::lane_br, $sformatf("branch cond %0d kind %0d", cond_bits, kind),
               ex_pkg::alu_addq, ex_pkg::opa_is_npc, ex_pkg::opb_is_br_disp, inst, t1,
               {$urandom, $urandom});
    issue_cond_branch   = (kind == 1);
    issue_uncond_branch = (kind == 2);
    take = (kind == 2) || ((kind == 1) && model_brcond(cond_bits, t1));
    exp_take.push_back(take);
    // target is the lane 4 sum, else fall through
    exp_pc.push_back(take ? exp_value[ex_pkg::lane_br][$] : issue_npc[ex_pkg::lane_br]);
  endtask

  ////////////////////
  // completion checks
  ////////////////////
  always @(negedge clock) begin
    for (int l = 0; l < ex_pkg::num_lanes; l++) begin
      if (cdb_valid[l]) begin
        if (exp_tag[l].size() == 0) begin
          stop_run($sformatf("lane %0d completed with nothing outstanding", l));
        end else begin
          check_value({exp_name[l][0], " tag"}, 64'(exp_tag[l][0]), 64'(cdb_tag[l]));
          check_value({exp_name[l][0], " value"}, exp_value[l][0], cdb_value[l]);
          check_value({exp_name[l][0], " cycle"}, 64'(exp_due[l][0]), 64'(cycle));
          if (l == ex_pkg::lane_br) begin
            check_value({exp_name[l][0], " take"}, 64'(exp_take[0]), 64'(take_branch));
            check_value({exp_name[l][0], " redirect"}, exp_pc[0], redirect_pc);
            void'(exp_take.pop_front());
            void'(exp_pc.pop_front());
          end
          void'(exp_name[l].pop_front());
          void'(exp_tag[l].pop_front());
          void'(exp_value[l].pop_front());
          void'(exp_due[l].pop_front());
        end
      end else if (exp_due[l].size() != 0 && exp_due[l][0] <= cycle) begin
        stop_run($sformatf("lane %0d missed its completion at cycle %0d", l, cycle));
      end
    end
    // also covers the reset window
    assert (cdb_valid[ex_pkg::lane_br] || !take_branch)
      else stop_run("take_branch high without a branch completion");
  end

  initial begin
    #(limit_cycles * 2 * half_period);
    stop_run("watchdog expired before all expected completions arrived");
  end

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    void'($urandom(21));
    clock = 1'b0;
    rst_n = 1'b0;
    drive_idle();
    // every lane claims valid while reset is held
    issue_valid = '1;
    repeat (reset_cycles) @(posedge clock);
    #1;
    rst_n = 1'b1;
    issue_valid = '0;

    // first half every lane valid, second half random valids
    for (int i = 0; i < main_cycles; i++) begin
      @(posedge clock);
      #1;
      drive_idle();
      if (i < main_cycles / 2 || $urandom_range(3) != 0) begin
        issue_lane(0, $sformatf("lane 0 %0d", i % 16), ex_pkg::alu_func_t'(5'(i % 16)),
                   ex_pkg::opa_is_rega, ex_pkg::opb_is_regb, $urandom,
                   pick_operand(), pick_operand());
      end
      if (i < main_cycles / 2 || $urandom_range(3) != 0) begin
        issue_lane(1, $sformatf("lane 1 %0d", (i + 5) % 16),
                   ex_pkg::alu_func_t'(5'((i + 5) % 16)), ex_pkg::opa_is_rega,
                   ex_pkg::opb_is_regb, $urandom, pick_operand(), pick_operand());
      end
      if (i < main_cycles / 2 || $urandom_range(3) != 0) begin
        issue_lane(2, $sformatf("mem lane opa %0d opb %0d", i % 4, (i / 4) % 3),
                   ex_pkg::alu_func_t'(5'($urandom_range(15))),
                   ex_pkg::opa_sel_t'(2'(i % 4)), ex_pkg::opb_sel_t'(2'((i / 4) % 3)),
                   $urandom, pick_operand(), pick_operand());
      end
      // back to back products in the first half
      if (i < main_cycles / 2 || $urandom_range(1) != 0) begin
        issue_lane(3, "mult", ex_pkg::alu_addq, ex_pkg::opa_is_rega, ex_pkg::opb_is_regb,
                   $urandom, pick_operand(), pick_operand());
      end
      if (i < main_cycles / 2 || $urandom_range(3) != 0) begin
        issue_branch(3'(i % 8), (i / 8) % 3);
      end
    end

    // idle with junk controls, nothing may complete
    repeat (idle_cycles) begin
      @(posedge clock);
      #1;
      drive_idle();
    end
    while (queues_pending()) begin
      @(posedge clock);
    end
    repeat (mult_stages + 4) @(posedge clock);
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
source/ex_pkg.sv
source/ex_alu.sv
source/ex_operand_stage.sv
source/ex_mult.sv
source/ex_complete_stage.sv
source/ex_stage.sv
bench/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
# exits non-zero on a build error, a simulator error or a failing check

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module ex_stage_tb -Mdir "$build_dir" -o ex_stage_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/ex_stage_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "tests failed" "$log_file"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0

// ==== source/ex_alu.sv ====
// single-lane integer alu, purely combinational
// shifts use only opb[5:0]
// unused function codes give a marker pattern on result
`timescale 1ns/100ps

module ex_alu (
  input  ex_pkg::word_t     opa,
  input  ex_pkg::word_t     opb,
  input  ex_pkg::alu_func_t func,
  output ex_pkg::word_t     result
);

  logic [5:0] shamt;
  logic       ult;
  logic       slt;

  assign shamt = opb[5:0];
  assign ult   = (opa < opb);

  // signs differ means the negative one is smaller
  // otherwise unsigned order holds
  assign slt = (opa[63] != opb[63]) ? opa[63] : ult;

  always_comb begin
    case (func)
      ex_pkg::alu_addq:   result = opa + opb;
      ex_pkg::alu_subq:   result = opa - opb;
      ex_pkg::alu_and:    result = opa & opb;
      ex_pkg::alu_bic:    result = opa & ~opb;
      ex_pkg::alu_bis:    result = opa | opb;
      ex_pkg::alu_ornot:  result = opa | ~opb;
      ex_pkg::alu_xor:    result = opa ^ opb;
      ex_pkg::alu_eqv:    result = opa ^ ~opb;
      ex_pkg::alu_srl:    result = opa >> shamt;
      ex_pkg::alu_sll:    result = opa << shamt;
      // sign bit fills from the top
      ex_pkg::alu_sra:    result = $signed(opa) >>> shamt;
      // compares return 0 or 1
      ex_pkg::alu_cmpult: result = {63'd0, ult};
      ex_pkg::alu_cmpeq:  result = {63'd0, opa == opb};
      ex_pkg::alu_cmpule: result = {63'd0, ult | (opa == opb)};
      ex_pkg::alu_cmplt:  result = {63'd0, slt};
      ex_pkg::alu_cmple:  result = {63'd0, slt | (opa == opb)};
      default:            result = 64'hdeadbeefbaadbeef;
    endcase
  end

endmodule

// ==== source/ex_complete_stage.sv ====
// branch condition test, redirect and completion register
// lane 3 completes from the multiplier, the rest from alu results
// take_branch is a one-cycle pulse aligned with the lane 4 completion
`timescale 1ns/100ps

module ex_complete_stage (
  input  logic                                  clock,
  input  logic                                  rst_n,
  input  ex_pkg::word_t [ex_pkg::num_lanes-1:0] alu_result,
  input  logic          [ex_pkg::num_lanes-1:0] op_valid,
  input  ex_pkg::tag_t  [ex_pkg::num_lanes-1:0] op_tag,
  input  ex_pkg::word_t                         op_npc,
  input  ex_pkg::word_t                         op_t1,
  input  logic          [2:0]                   op_cond_bits,
  input  logic                                  op_cond_branch,
  input  logic                                  op_uncond_branch,
  input  logic                                  mult_valid,
  input  ex_pkg::tag_t                          mult_tag,
  input  ex_pkg::word_t                         mult_product,
  output logic          [ex_pkg::num_lanes-1:0] cdb_valid,
  output ex_pkg::tag_t  [ex_pkg::num_lanes-1:0] cdb_tag,
  output ex_pkg::word_t [ex_pkg::num_lanes-1:0] cdb_value,
  output logic                                  take_branch,
  output ex_pkg::word_t                         redirect_pc
);

  logic                                  cond;
  logic                                  taken;
  logic          [ex_pkg::num_lanes-1:0] next_valid;
  ex_pkg::tag_t  [ex_pkg::num_lanes-1:0] next_tag;
  ex_pkg::word_t [ex_pkg::num_lanes-1:0] next_value;

  ////////////////////
  // branch condition
  ////////////////////
  always_comb begin
    case (op_cond_bits[1:0])
      2'b00:   cond = ~op_t1[0];                      // lbc
      2'b01:   cond = (op_t1 == '0);                  // eq
      2'b10:   cond = op_t1[63];                      // lt
      default: cond = op_t1[63] | (op_t1 == '0);      // le
    endcase
    // third bit inverts the test
    if (op_cond_bits[2]) begin
      cond = ~cond;
    end
  end

  assign taken = op_valid[ex_pkg::lane_br]
               & (op_uncond_branch | (op_cond_branch & cond));

  // multiplier lane replaces its slot
  always_comb begin
    next_valid = op_valid;
    next_tag   = op_tag;
    next_value = alu_result;
    next_valid[ex_pkg::lane_mult] = mult_valid;
    next_tag[ex_pkg::lane_mult]   = mult_tag;
    next_value[ex_pkg::lane_mult] = mult_product;
  end

  ////////////////////
  // completion register
  ////////////////////
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      cdb_valid   <= '0;
      take_branch <= 1'b0;
    end else begin
      cdb_valid   <= next_valid;
      take_branch <= taken;
    end
  end

  always_ff @(posedge clock) begin
    cdb_tag     <= next_tag;
    cdb_value   <= next_value;
    // target from the branch alu, else fall through
    redirect_pc <= taken ? alu_result[ex_pkg::lane_br] : op_npc;
  end

  a_br_kind: assert property (@(posedge clock) disable iff (!rst_n)
    op_valid[ex_pkg::lane_br] |-> !(op_cond_branch && op_uncond_branch));

  // no two lanes write the same register in one cycle
  for (genvar a = 0; a < ex_pkg::num_lanes; a++) begin : g_tag_a
    for (genvar b = a + 1; b < ex_pkg::num_lanes; b++) begin : g_tag_b
      a_tag_unique: assert property (@(posedge clock) disable iff (!rst_n)
        !(cdb_valid[a] && cdb_valid[b] && (cdb_tag[a] == cdb_tag[b])));
    end
  end

endmodule

// ==== source/ex_mult.sv ====
// pipelined 64x64 multiplier, low 64 bits of product
// mult_stages must divide 64, one slice of mplier per stage
// accepts one item per cycle, latency is mult_stages
`timescale 1ns/100ps

module ex_mult #(
  parameter int mult_stages = 4
) (
  input  logic          clock,
  input  logic          rst_n,
  input  logic          start,
  input  ex_pkg::tag_t  tag,
  input  ex_pkg::word_t mcand,
  input  ex_pkg::word_t mplier,
  output logic          done,
  output ex_pkg::tag_t  done_tag,
  output ex_pkg::word_t product
);

  // bits of mplier consumed per stage
  localparam int slice_w = 64 / mult_stages;

  logic          stage_valid  [mult_stages];
  ex_pkg::tag_t  stage_tag    [mult_stages];
  ex_pkg::word_t stage_sum    [mult_stages];
  ex_pkg::word_t stage_mcand  [mult_stages];
  ex_pkg::word_t stage_mplier [mult_stages];

  for (genvar s = 0; s < mult_stages; s++) begin : g_stage
    logic          valid_in;
    ex_pkg::tag_t  tag_in;
    ex_pkg::word_t sum_in;
    ex_pkg::word_t mcand_in;
    ex_pkg::word_t mplier_in;
    ex_pkg::word_t partial;

    if (s == 0) begin : g_first
      // running sum starts at zero
      assign valid_in  = start;
      assign tag_in    = tag;
      assign sum_in    = '0;
      assign mcand_in  = mcand;
      assign mplier_in = mplier;
    end else begin : g_next
      assign valid_in  = stage_valid[s-1];
      assign tag_in    = stage_tag[s-1];
      assign sum_in    = stage_sum[s-1];
      assign mcand_in  = stage_mcand[s-1];
      assign mplier_in = stage_mplier[s-1];
    end

    // partial product of the low slice
    assign partial = mcand_in * 64'(mplier_in[slice_w-1:0]);

    always_ff @(posedge clock) begin
      if (!rst_n) begin
        stage_valid[s] <= 1'b0;
      end else begin
        stage_valid[s] <= valid_in;
      end
    end

    // payload moves with valid, no reset
    always_ff @(posedge clock) begin
      stage_tag[s]    <= tag_in;
      stage_sum[s]    <= sum_in + partial;
      stage_mcand[s]  <= mcand_in << slice_w;
      stage_mplier[s] <= mplier_in >> slice_w;
    end
  end

  assign done     = stage_valid[mult_stages-1];
  assign done_tag = stage_tag[mult_stages-1];
  assign product  = stage_sum[mult_stages-1];

  a_stages_divide: assert property (@(posedge clock) (64 % mult_stages) == 0);

endmodule

// ==== source/ex_operand_stage.sv ====
// operand select and first pipeline register for all lanes
// issue sampled on one edge, operands visible after it
// only op_valid is cleared by rst_n
`timescale 1ns/100ps

module ex_operand_stage (
  input  logic                                         clock,
  input  logic                                         rst_n,
  input  logic          [ex_pkg::num_lanes-1:0]        issue_valid,
  input  ex_pkg::tag_t  [ex_pkg::num_lanes-1:0]        issue_tag,
  input  ex_pkg::inst_t [ex_pkg::num_lanes-1:0]        issue_inst,
  input  ex_pkg::word_t [ex_pkg::num_lanes-1:0]        issue_npc,
  input  ex_pkg::alu_func_t [ex_pkg::num_lanes-1:0]    issue_alu_func,
  input  ex_pkg::opa_sel_t  [ex_pkg::num_lanes-1:0]    issue_opa_sel,
  input  ex_pkg::opb_sel_t  [ex_pkg::num_lanes-1:0]    issue_opb_sel,
  input  ex_pkg::word_t [ex_pkg::num_lanes-1:0]        t1_value,
  input  ex_pkg::word_t [ex_pkg::num_lanes-1:0]        t2_value,
  input  logic                                         issue_cond_branch,
  input  logic                                         issue_uncond_branch,
  output logic          [ex_pkg::num_lanes-1:0]        op_valid,
  output ex_pkg::tag_t  [ex_pkg::num_lanes-1:0]        op_tag,
  output ex_pkg::word_t [ex_pkg::num_lanes-1:0]        op_npc,
  output ex_pkg::alu_func_t [ex_pkg::num_lanes-1:0]    op_func,
  output ex_pkg::word_t [ex_pkg::num_lanes-1:0]        op_opa,
  output ex_pkg::word_t [ex_pkg::num_lanes-1:0]        op_opb,
  output ex_pkg::word_t                                op_t1,
  output logic          [2:0]                          op_cond_bits,
  output logic                                         op_cond_branch,
  output logic                                         op_uncond_branch
);

  ex_pkg::word_t [ex_pkg::num_lanes-1:0] mem_disp;
  ex_pkg::word_t [ex_pkg::num_lanes-1:0] br_disp;
  ex_pkg::word_t [ex_pkg::num_lanes-1:0] alu_imm;
  ex_pkg::word_t [ex_pkg::num_lanes-1:0] opa_mux;
  ex_pkg::word_t [ex_pkg::num_lanes-1:0] opb_mux;

  ////////////////////
  // immediates and muxes
  ////////////////////
  always_comb begin
    for (int i = 0; i < ex_pkg::num_lanes; i++) begin
      // memory format, sign-extended 16 bits
      mem_disp[i] = {{48{issue_inst[i][15]}}, issue_inst[i][15:0]};
      // branch format, word displacement
      br_disp[i]  = {{41{issue_inst[i][20]}}, issue_inst[i][20:0], 2'b00};
      // operate format literal, zero-extended
      alu_imm[i]  = {56'd0, issue_inst[i][20:13]};

      case (issue_opa_sel[i])
        ex_pkg::opa_is_rega:     opa_mux[i] = t1_value[i];
        ex_pkg::opa_is_mem_disp: opa_mux[i] = mem_disp[i];
        ex_pkg::opa_is_npc:      opa_mux[i] = issue_npc[i];
        default:                 opa_mux[i] = ~64'h3;
      endcase

      case (issue_opb_sel[i])
        ex_pkg::opb_is_regb:    opb_mux[i] = t2_value[i];
        ex_pkg::opb_is_alu_imm: opb_mux[i] = alu_imm[i];
        ex_pkg::opb_is_br_disp: opb_mux[i] = br_disp[i];
        // marker for a bad select
        default:                opb_mux[i] = 64'hbaadbeefdeadbeef;
      endcase
    end
  end

  ////////////////////
  // pipeline register
  ////////////////////
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      op_valid <= '0;
    end else begin
      op_valid <= issue_valid;
    end
  end

  always_ff @(posedge clock) begin
    op_tag           <= issue_tag;
    op_npc           <= issue_npc;
    op_func          <= issue_alu_func;
    op_opa           <= opa_mux;
    op_opb           <= opb_mux;
    // branch lane keeps rega for the condition test
    op_t1            <= t1_value[ex_pkg::lane_br];
    op_cond_bits     <= issue_inst[ex_pkg::lane_br][28:26];
    op_cond_branch   <= issue_cond_branch;
    op_uncond_branch <= issue_uncond_branch;
  end

  // a valid issue never uses the spare opb code
  for (genvar l = 0; l < ex_pkg::num_lanes; l++) begin : g_chk
    a_opb_sel: assert property (@(posedge clock) disable iff (!rst_n)
      issue_valid[l] |-> (issue_opb_sel[l] != 2'h3));
  end

endmodule

// ==== source/ex_pkg.sv ====
// shared types and constants for the execute stage
// lane numbering is fixed, lane 3 is the only multi-cycle lane
// opb code 2'b11 is not a legal select
package ex_pkg;

  // data word, also used for pcs
  typedef logic [63:0] word_t;
  // raw instruction word
  typedef logic [31:0] inst_t;
  // destination physical register tag
  typedef logic [5:0] tag_t;

  ////////////////////
  // alu functions
  ////////////////////
  typedef enum logic [4:0] {
    alu_addq   = 5'h00,
    alu_subq   = 5'h01,
    alu_and    = 5'h02,
    alu_bic    = 5'h03,
    alu_bis    = 5'h04,
    alu_ornot  = 5'h05,
    alu_xor    = 5'h06,
    alu_eqv    = 5'h07,
    alu_srl    = 5'h08,
    alu_sll    = 5'h09,
    alu_sra    = 5'h0a,
    alu_cmpult = 5'h0b,
    alu_cmpeq  = 5'h0c,
    alu_cmpule = 5'h0d,
    alu_cmplt  = 5'h0e,
    alu_cmple  = 5'h0f
  } alu_func_t;

  // operand a sources
  typedef enum logic [1:0] {
    opa_is_rega     = 2'h0,
    opa_is_mem_disp = 2'h1,
    opa_is_npc      = 2'h2,
    opa_is_not3     = 2'h3
  } opa_sel_t;

  // operand b sources, 2'h3 unused
  typedef enum logic [1:0] {
    opb_is_regb    = 2'h0,
    opb_is_alu_imm = 2'h1,
    opb_is_br_disp = 2'h2
  } opb_sel_t;

  ////////////////////
  // lane numbering
  ////////////////////
  localparam int num_lanes = 5;
  localparam int lane_alu0 = 0;
  localparam int lane_alu1 = 1;
  localparam int lane_mem  = 2;
  localparam int lane_mult = 3;
  localparam int lane_br   = 4;

endpackage

// ==== source/ex_stage.sv ====
// execute stage top, five lanes
// alu lanes complete 2 cycles after issue, multiplier mult_stages+2
// no stall input, results are always taken
`timescale 1ns/100ps

module ex_stage #(
  parameter int mult_stages = 4
) (
  input  logic                                      clock,
  input  logic                                      rst_n,
  input  logic          [ex_pkg::num_lanes-1:0]     issue_valid,
  input  ex_pkg::tag_t  [ex_pkg::num_lanes-1:0]     issue_tag,
  input  ex_pkg::inst_t [ex_pkg::num_lanes-1:0]     issue_inst,
  input  ex_pkg::word_t [ex_pkg::num_lanes-1:0]     issue_npc,
  input  ex_pkg::alu_func_t [ex_pkg::num_lanes-1:0] issue_alu_func,
  input  ex_pkg::opa_sel_t  [ex_pkg::num_lanes-1:0] issue_opa_sel,
  input  ex_pkg::opb_sel_t  [ex_pkg::num_lanes-1:0] issue_opb_sel,
  input  ex_pkg::word_t [ex_pkg::num_lanes-1:0]     t1_value,
  input  ex_pkg::word_t [ex_pkg::num_lanes-1:0]     t2_value,
  input  logic                                      issue_cond_branch,
  input  logic                                      issue_uncond_branch,
  output logic          [ex_pkg::num_lanes-1:0]     cdb_valid,
  output ex_pkg::tag_t  [ex_pkg::num_lanes-1:0]     cdb_tag,
  output ex_pkg::word_t [ex_pkg::num_lanes-1:0]     cdb_value,
  output logic                                      take_branch,
  output ex_pkg::word_t                             redirect_pc
);

  logic              [ex_pkg::num_lanes-1:0] op_valid;
  ex_pkg::tag_t      [ex_pkg::num_lanes-1:0] op_tag;
  ex_pkg::word_t     [ex_pkg::num_lanes-1:0] op_npc;
  ex_pkg::alu_func_t [ex_pkg::num_lanes-1:0] op_func;
  ex_pkg::word_t     [ex_pkg::num_lanes-1:0] op_opa;
  ex_pkg::word_t     [ex_pkg::num_lanes-1:0] op_opb;
  ex_pkg::word_t                             op_t1;
  logic              [2:0]                   op_cond_bits;
  logic                                      op_cond_branch;
  logic                                      op_uncond_branch;
  ex_pkg::word_t     [ex_pkg::num_lanes-1:0] alu_result;
  logic                                      mult_valid;
  ex_pkg::tag_t                              mult_tag;
  ex_pkg::word_t                             mult_product;

  ex_operand_stage u_operand (.*);

  ////////////////////
  // per-lane units
  ////////////////////
  for (genvar l = 0; l < ex_pkg::num_lanes; l++) begin : g_lane
    if (l != ex_pkg::lane_mult) begin : g_alu
      ex_alu u_alu (
        .opa    (op_opa[l]),
        .opb    (op_opb[l]),
        .func   (op_func[l]),
        .result (alu_result[l])
      );
    end else begin : g_no_alu
      // no alu here, complete stage uses the product
      assign alu_result[l] = '0;
    end
  end

  ex_mult #(
    .mult_stages (mult_stages)
  ) u_mult (
    .clock    (clock),
    .rst_n    (rst_n),
    .start    (op_valid[ex_pkg::lane_mult]),
    .tag      (op_tag[ex_pkg::lane_mult]),
    .mcand    (op_opa[ex_pkg::lane_mult]),
    .mplier   (op_opb[ex_pkg::lane_mult]),
    .done     (mult_valid),
    .done_tag (mult_tag),
    .product  (mult_product)
  );

  ex_complete_stage u_complete (
    .clock            (clock),
    .rst_n            (rst_n),
    .alu_result       (alu_result),
    .op_valid         (op_valid),
    .op_tag           (op_tag),
    .op_npc           (op_npc[ex_pkg::lane_br]),
    .op_t1            (op_t1),
    .op_cond_bits     (op_cond_bits),
    .op_cond_branch   (op_cond_branch),
    .op_uncond_branch (op_uncond_branch),
    .mult_valid       (mult_valid),
    .mult_tag         (mult_tag),
    .mult_product     (mult_product),
    .cdb_valid        (cdb_valid),
    .cdb_tag          (cdb_tag),
    .cdb_value        (cdb_value),
    .take_branch      (take_branch),
    .redirect_pc      (redirect_pc)
  );

endmodule
